/* hw/isa_cov_pkg.sv */
package isa_cov_pkg;

    // ----------------------------------------
    // RISC-V major opcodes, bits 6:0
    // ----------------------------------------
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011; // RV64 word ops
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_AMO       = 7'b0101111;
    localparam logic [6:0] OPC_MISC_MEM  = 7'b0001111; // FENCE, FENCE.I
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // Funct7, bits 31:25
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB / SRA
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // M extension

    // Instruction classes, one counter each
    typedef enum logic [3:0] {
        CLS_OTHER     = 4'd0,
        CLS_LUI       = 4'd1,
        CLS_AUIPC     = 4'd2,
        CLS_JAL       = 4'd3,
        CLS_JALR      = 4'd4,
        CLS_BRANCH    = 4'd5,
        CLS_LOAD      = 4'd6,
        CLS_STORE     = 4'd7,
        CLS_OP_IMM    = 4'd8,
        CLS_OP_IMM_32 = 4'd9,
        CLS_OP        = 4'd10,
        CLS_OP_32     = 4'd11,
        CLS_MULDIV    = 4'd12,
        CLS_AMO       = 4'd13,
        CLS_MISC_MEM  = 4'd14,
        CLS_SYSTEM    = 4'd15
    } class_t;

    localparam int NUM_CLASSES = 16;
    localparam int CNT_W       = 32;

    // Counter read index, 16 selects the total
    typedef logic [4:0] rd_idx_t;
    localparam rd_idx_t IDX_TOTAL = rd_idx_t'(NUM_CLASSES);

    // ----------------------------------------
    // AXI4-Lite register map
    // ----------------------------------------
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] ADDR_TOTAL = 8'h40;
    localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL  = 8'h44; // bit 0 clears

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* hw/insn_classifier.sv */
module insn_classifier
    import isa_cov_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic [31:0] i_insn,
    output logic        o_hit,
    output class_t      o_class
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    class_t     cls_next;

    assign opcode = i_insn[6:0];
    assign funct7 = i_insn[31:25];

    // ----------------------------------------
    // Opcode / funct7 decode
    // ----------------------------------------
    always_comb begin
        case (opcode)
            OPC_LUI:       cls_next = CLS_LUI;
            OPC_AUIPC:     cls_next = CLS_AUIPC;
            OPC_JAL:       cls_next = CLS_JAL;
            OPC_JALR:      cls_next = CLS_JALR;
            OPC_BRANCH:    cls_next = CLS_BRANCH;
            OPC_LOAD:      cls_next = CLS_LOAD;
            OPC_STORE:     cls_next = CLS_STORE;
            OPC_OP_IMM:    cls_next = CLS_OP_IMM;
            OPC_OP_IMM_32: cls_next = CLS_OP_IMM_32;
            OPC_AMO:       cls_next = CLS_AMO;
            OPC_MISC_MEM:  cls_next = CLS_MISC_MEM;
            OPC_SYSTEM:    cls_next = CLS_SYSTEM;
            OPC_OP: begin
                // Register-register ops split on funct7
                if (funct7 == F7_MULDIV) begin
                    cls_next = CLS_MULDIV;
                end else if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    cls_next = CLS_OP;
                end else begin
                    cls_next = CLS_OTHER;
                end
            end
            OPC_OP_32: begin
                // MULW/DIVW etc. land in the same M bucket
                if (funct7 == F7_MULDIV) begin
                    cls_next = CLS_MULDIV;
                end else if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    cls_next = CLS_OP_32;
                end else begin
                    cls_next = CLS_OTHER;
                end
            end
            default:       cls_next = CLS_OTHER; // Unknown or reserved
        endcase
    end

    // ----------------------------------------
    // Output register, one cycle after commit
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hit   <= 1'b0;
            o_class <= CLS_OTHER;
        end else begin
            o_hit <= i_valid;
            if (i_valid) begin
                o_class <= cls_next; // Holds otherwise
            end
        end
    end

endmodule

/* hw/hit_counter_bank.sv */
module hit_counter_bank
    import isa_cov_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_hit,
    input  class_t           i_class,
    input  logic             i_clear,
    input  rd_idx_t          i_rd_idx,
    output logic [CNT_W-1:0] o_rd_data
);

    logic [CNT_W-1:0] cnt_q [NUM_CLASSES];
    logic [CNT_W-1:0] total_q;

    // ----------------------------------------
    // Saturating counters
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_CLASSES; i++) begin
                cnt_q[i] <= '0;
            end
            total_q <= '0;
        end else if (i_clear) begin
            // Clear beats a hit in the same cycle
            for (int i = 0; i < NUM_CLASSES; i++) begin
                cnt_q[i] <= '0;
            end
            total_q <= '0;
        end else if (i_hit) begin
            if (cnt_q[i_class] != '1) begin
                cnt_q[i_class] <= cnt_q[i_class] + 1'b1;
            end
            if (total_q != '1) begin
                total_q <= total_q + 1'b1; // Stick at all ones
            end
        end
    end

    // Read mux
    always_comb begin
        if (i_rd_idx == IDX_TOTAL) begin
            o_rd_data = total_q;
        end else if (i_rd_idx < IDX_TOTAL) begin
            o_rd_data = cnt_q[i_rd_idx[3:0]];
        end else begin
            o_rd_data = '0; // Out of range
        end
    end

endmodule

/* hw/cov_csr_axil.sv */
module cov_csr_axil
    import isa_cov_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Write address / data / response
    input  logic                  i_awvalid,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  logic                  i_wvalid,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    input  logic [3:0]            i_wstrb,
    output logic                  o_wready,
    output logic                  o_bvalid,
    output logic [1:0]            o_bresp,
    input  logic                  i_bready,

    // Read address / data
    input  logic                  i_arvalid,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    output logic [AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    input  logic                  i_rready,

    // Counter bank side
    output logic                  o_clear,
    output rd_idx_t               o_rd_idx,
    input  logic [CNT_W-1:0]      i_rd_data
);

    logic                  wr_hs;
    logic                  rd_hs;
    logic                  rd_mapped;
    logic                  bvalid_q;
    logic                  rvalid_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    logic [1:0]            rresp_q;

    // ----------------------------------------
    // Write channel
    // ----------------------------------------
    // Address and data are taken in the same cycle
    assign wr_hs     = i_awvalid && i_wvalid && !bvalid_q;
    assign o_awready = wr_hs;
    assign o_wready  = wr_hs;

    // Only CTRL bit 0 does anything
    assign o_clear = wr_hs && (i_awaddr == ADDR_CTRL) && i_wstrb[0] && i_wdata[0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_hs) begin
            bvalid_q <= 1'b1;
        end else if (i_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    assign o_bvalid = bvalid_q;
    assign o_bresp  = RESP_OKAY; // Writes never fail

    // ----------------------------------------
    // Read channel
    // ----------------------------------------
    assign o_arready = !rvalid_q;
    assign rd_hs     = i_arvalid && !rvalid_q;

    // Word aligned, 0x00 up to and including ADDR_TOTAL
    assign rd_mapped = (i_araddr[1:0] == 2'b00) && (i_araddr <= ADDR_TOTAL);
    assign o_rd_idx  = rd_idx_t'(i_araddr[6:2]);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            rresp_q  <= RESP_OKAY;
        end else if (rd_hs) begin
            rvalid_q <= 1'b1;
            if (rd_mapped) begin
                rdata_q <= i_rd_data; // Snapshot at handshake
                rresp_q <= RESP_OKAY;
            end else begin
                rdata_q <= '0;
                rresp_q <= RESP_SLVERR;
            end
        end else if (i_rready) begin
            rvalid_q <= 1'b0; // Data stays put
        end
    end

    assign o_rvalid = rvalid_q;
    assign o_rdata  = rdata_q;
    assign o_rresp  = rresp_q;

endmodule

/* hw/isa_cov_monitor.sv */
module isa_cov_monitor
    import isa_cov_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Commit port
    input  logic                  i_commit_valid,
    input  logic [31:0]           i_commit_insn,

    // AXI4-Lite slave
    input  logic                  i_awvalid,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  logic                  i_wvalid,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    input  logic [3:0]            i_wstrb,
    output logic                  o_wready,
    output logic                  o_bvalid,
    output logic [1:0]            o_bresp,
    input  logic                  i_bready,
    input  logic                  i_arvalid,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    output logic [AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    input  logic                  i_rready
);

    logic             hit;
    class_t           hit_class;
    logic             clear;
    rd_idx_t          rd_idx;
    logic [CNT_W-1:0] rd_data;

    // ----------------------------------------
    // Decode, count, register access
    // ----------------------------------------
    insn_classifier insn_classifier_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_commit_valid),
        .i_insn  (i_commit_insn),
        .o_hit   (hit),
        .o_class (hit_class)
    );

    hit_counter_bank hit_counter_bank_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_hit     (hit),
        .i_class   (hit_class),
        .i_clear   (clear),
        .i_rd_idx  (rd_idx),
        .o_rd_data (rd_data)
    );

    cov_csr_axil cov_csr_axil_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .i_awaddr  (i_awaddr),
        .o_awready (o_awready),
        .i_wvalid  (i_wvalid),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .o_bresp   (o_bresp),
        .i_bready  (i_bready),
        .i_arvalid (i_arvalid),
        .i_araddr  (i_araddr),
        .o_arready (o_arready),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .i_rready  (i_rready),
        .o_clear   (clear),
        .o_rd_idx  (rd_idx),
        .i_rd_data (rd_data)
    );

endmodule

/* dv/isa_cov_model.svh */
`ifndef ISA_COV_MODEL_SVH
`define ISA_COV_MODEL_SVH

// Listed opcodes in class order
// CLS_MULDIV sits between OP_32 and AMO
logic [6:0] opc_list [14] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                              OPC_STORE, OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32,
                              OPC_AMO, OPC_MISC_MEM, OPC_SYSTEM};
int         exp_cnt [NUM_CLASSES];
int         exp_total;

task automatic model_clear();
    exp_cnt   = '{default: 0};
    exp_total = 0;
endtask

// Expected class index of one committed instruction
function automatic int model_class(input logic [31:0] insn);
    int cls;
    cls = int'(CLS_OTHER);
    for (int i = 0; i < 14; i++) begin
        if (insn[6:0] == opc_list[i]) begin
            cls = (i < 11) ? i + 1 : i + 2; // Skip the MULDIV slot
        end
    end
    if (cls == int'(CLS_OP) || cls == int'(CLS_OP_32)) begin
        if (insn[31:25] == F7_MULDIV) begin
            cls = int'(CLS_MULDIV);
        end else if (insn[31:25] != F7_BASE && insn[31:25] != F7_ALT) begin
            cls = int'(CLS_OTHER); // Reserved funct7
        end
    end
    return cls;
endfunction

task automatic model_update(input logic [31:0] insn);
    exp_cnt[model_class(insn)]++;
    exp_total++;
endtask

// AXI4-Lite read that starts and ends on a falling edge
task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    i_arvalid = 1'b1;
    i_araddr  = addr;
    while (!o_arready) @(negedge i_clk);
    @(negedge i_clk);                            // Address taken on the edge between
    i_arvalid = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge i_clk); // Back-pressure
    i_rready = 1'b1;
    while (!o_rvalid) @(negedge i_clk);
    data = o_rdata;
    resp = o_rresp;
    @(negedge i_clk);
    i_rready = 1'b0;
endtask

// AXI4-Lite write with address and data together
task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = addr;
    i_wdata   = data;
    while (o_bvalid) @(negedge i_clk);
    #1;
    // Both ready together while no response is pending
    assert (o_awready && o_wready) else begin
        errors++;
        $display("error %0t: write to 0x%02h not accepted, awready %0b wready %0b",
                 $time, addr, o_awready, o_wready);
    end
    @(negedge i_clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge i_clk);
    i_bready = 1'b1;
    while (!o_bvalid) @(negedge i_clk);
    resp = o_bresp;
    @(negedge i_clk);
    i_bready = 1'b0;
endtask

`endif

/* dv/isa_cov_tb.sv */
module isa_cov_tb
    import isa_cov_pkg::*;
();

    localparam int N_BEATS_A = 2000;
    localparam int N_BEATS_B = 500;
    localparam int N_READS   = 90;
    localparam int TIMEOUT   = (N_BEATS_A + N_BEATS_B + 40 * N_READS) * 4 * 2;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n = 1'b0;
    logic                  i_commit_valid = 1'b0;
    logic [31:0]           i_commit_insn = '0;
    logic                  i_awvalid = 1'b0, i_wvalid = 1'b0, i_bready = 1'b0;
    logic                  i_arvalid = 1'b0, i_rready = 1'b0;
    logic [AXI_ADDR_W-1:0] i_awaddr = '0, i_araddr = '0;
    logic [AXI_DATA_W-1:0] i_wdata = '0;
    logic [3:0]            i_wstrb = 4'hf;
    logic                  o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
    logic [AXI_DATA_W-1:0] o_rdata;
    logic [1:0]            o_bresp, o_rresp;
    logic [6:0]            f7_list [3] = '{F7_BASE, F7_ALT, F7_MULDIV};
    int                    errors = 0;

    isa_cov_monitor isa_cov_monitor_i (.*);

    `include "isa_cov_model.svh"

    always #2 i_clk = ~i_clk;

    // ----------------------------------------
    // Stimulus and checks
    // ----------------------------------------
    task automatic run_beats(input int n);
        for (int b = 0; b < n; b++) begin
            @(negedge i_clk);
            i_commit_valid = ($urandom_range(99, 0) < 70);
            i_commit_insn  = $urandom();
            if ($urandom_range(14, 0) != 0) begin   // Mostly listed opcodes
                i_commit_insn[6:0] = opc_list[$urandom_range(13, 0)];
            end
            if ($urandom_range(3, 0) != 0) begin
                i_commit_insn[31:25] = f7_list[$urandom_range(2, 0)];
            end
            if (i_commit_valid) begin
                model_update(i_commit_insn);
            end
        end
        @(negedge i_clk);
        i_commit_valid = 1'b0;
        repeat (4) @(negedge i_clk); // Let the pipeline drain
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        assert (data == exp_data && resp == exp_resp) else begin
            errors++;
            $display("error %0t: read 0x%02h gave %0d resp %0d, expected %0d resp %0d",
                     $time, addr, data, resp, exp_data, exp_resp);
        end
    endtask

    // Every class counter, then the total
    task automatic check_all();
        for (int i = 0; i < NUM_CLASSES; i++) begin
            check_read(8'(4 * i), exp_cnt[i], RESP_OKAY);
        end
        check_read(ADDR_TOTAL, exp_total, RESP_OKAY);
    endtask

    task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        assert (resp == RESP_OKAY) else begin
            errors++;
            $display("error %0t: write to 0x%02h gave resp %0d", $time, addr, resp);
        end
    endtask

    initial begin
        void'($urandom(32'h2bb3));
        model_clear();
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_all();                          // All zero out of reset
        run_beats(N_BEATS_A);
        check_all();
        check_read(8'h48, 32'h0, RESP_SLVERR); // Unmapped
        check_read(8'hfc, 32'h0, RESP_SLVERR);
        write_ok(8'h08, 32'hffff_ffff);       // Counters are read only
        check_all();
        write_ok(ADDR_CTRL, 32'h1);
        model_clear();
        check_all();
        run_beats(N_BEATS_B);
        check_all();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Run timed out waiting for the DUT");
        $display("Errors found");
        $finish;
    end

endmodule

/* files.f */
+incdir+dv
hw/isa_cov_pkg.sv
hw/insn_classifier.sv
hw/hit_counter_bank.sv
hw/cov_csr_axil.sv
hw/isa_cov_monitor.sv
dv/isa_cov_tb.sv
